//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ctrl_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- cmd_fifo.sv
module cmd_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type T          = logic [7:0]
) (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic push_i,
    input  T     push_data_i,
    input  logic pop_i,
    output T     head_o,
    output logic empty_o,
    output logic full_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    T                 mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap explicitly so depths that are not a power of two work too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(FIFO_DEPTH));
    assign head_o  = mem[rd_ptr];

    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop);  // a full FIFO still takes a push on a pop

    always_ff @(posedge clk_i) begin
        if (do_push) mem[wr_ptr] <= push_data_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- ctrl_assertions.sv
module ctrl_assertions import ctrl_pkg::*; (
    input logic      clk_i,
    input logic      arst_n_i,
    input logic      wr_stb_i,
    input logic      spi_cs_o,
    input logic      spi_clk_o,
    input logic      overflow_o,
    input logic      evt_stb_o,
    input ctrl_src_e evt_src_o
);

    // sclk idles low whenever no slave is selected
    a_clk_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        spi_cs_o |-> !spi_clk_o)
        else $error("spi clock toggled with chip select high");

    a_ovf_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        overflow_o |-> wr_stb_i)
        else $error("overflow without a write strobe");

    a_src_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        evt_stb_o |-> !$isunknown(evt_src_o))
        else $error("event source unknown during a strobe");

endmodule

bind ctrl_top ctrl_assertions ctrl_assertions_inst (.*);

//--- ctrl_checker.sv
module ctrl_checker import ctrl_pkg::*; #(
    parameter int FIFO_DEPTH   = 4,
    parameter int CLKS_PER_BIT = 8
) (
    input logic              clk_i,
    input logic              arst_n_i,
    input logic              burst_i,
    input logic              wr_stb_i,
    input logic [ADDR_W-1:0] wr_addr_i,
    input logic [7:0]        wr_data_i,
    input logic              uart_tx_i,
    input logic              spi_clk_i,
    input logic              spi_mosi_i,
    input logic              spi_cs_i,
    input logic              evt_stb_i,
    input ctrl_src_e         evt_src_i,
    input logic [7:0]        evt_data_i,
    input logic              overflow_i
);

    logic [7:0] uart_q[$];
    spi_cmd_t   spi_q[$];
    logic [7:0] uart_ev_q[$];
    logic [7:0] spi_ev_q[$];
    int         errors = 0;
    int         switches = 0;
    int         ovf_count = 0;
    int         burst_pos = 0;
    int         first_hits = 0;
    int         spi_bits = 0;
    logic [7:0] spi_sh = '0;
    logic       last_sent = 1'b1;
    logic       sclk_prev = 1'b0;
    logic       cs_prev = 1'b1;
    logic       burst_prev = 1'b0;
    logic       have_src = 1'b0;
    ctrl_src_e  last_src = SRC_UART;

    task automatic mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
        $display("Fail %s expected %h got %h", name, exp, got);
        errors++;
    endtask

    task automatic flag_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // in the burst some writes are dropped, so a frame may skip ahead in the queue
    task automatic uart_frame(input logic [7:0] got);
        logic [7:0] exp;
        logic       found;
        found = 1'b0;
        if (!burst_i) begin
            if (uart_q.size() == 0) begin
                flag_problem("uart frame seen with no byte queued");
            end else begin
                exp = uart_q.pop_front();
                if (exp != got) mismatch("uart_tx_o", exp, got);
                uart_ev_q.push_back(exp);
            end
        end else begin
            while (uart_q.size() > 0 && !found) begin
                exp = uart_q.pop_front();
                if (exp == got) begin
                    found = 1'b1;
                    if (burst_pos < FIFO_DEPTH) first_hits++;
                end
                burst_pos++;
            end
            if (!found) flag_problem("uart burst frame does not follow the written order");
            uart_ev_q.push_back(got);
        end
    endtask

    always @(posedge clk_i) begin
        // every paced byte must be on the line before the burst starts
        if (burst_i && !burst_prev && uart_q.size() != 0) begin
            flag_problem("uart bytes were never sent");
        end
        burst_prev = burst_i;
        if (arst_n_i && wr_stb_i) begin
            if (wr_addr_i == ADDR_UART) uart_q.push_back(wr_data_i);
            if (wr_addr_i == ADDR_SPI) spi_q.push_back({1'b0, wr_data_i});
            if (wr_addr_i == ADDR_SPI_LAST) spi_q.push_back({1'b1, wr_data_i});
        end
        if (arst_n_i && overflow_i) begin
            if (burst_i) ovf_count++;
            else flag_problem("overflow pulsed during paced traffic");
        end
    end

    // uart frames are sampled in the middle of every bit
    initial begin
        logic [7:0] rx_byte;
        forever begin
            @(posedge clk_i);
            if (arst_n_i && !uart_tx_i) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk_i);
                if (uart_tx_i) flag_problem("uart start bit did not stay low");
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk_i);
                    rx_byte[i] = uart_tx_i;
                end
                repeat (CLKS_PER_BIT) @(posedge clk_i);
                if (!uart_tx_i) mismatch("uart_tx_o stop bit", 8'h01, 8'h00);
                uart_frame(rx_byte);
            end
        end
    end

    always @(posedge clk_i) begin
        spi_cmd_t exp;
        if (!arst_n_i) begin
            spi_bits = 0;
        end else begin
            if (!spi_cs_i && spi_clk_i && !sclk_prev) begin
                spi_sh = {spi_sh[6:0], spi_mosi_i};  // msb arrives first
                spi_bits++;
                if (spi_bits == 8) begin
                    spi_bits = 0;
                    if (spi_q.size() == 0) begin
                        flag_problem("spi byte seen with no byte queued");
                    end else begin
                        exp = spi_q.pop_front();
                        if (exp.data != spi_sh) mismatch("spi_mosi_o", exp.data, spi_sh);
                        last_sent = exp.last;
                        spi_ev_q.push_back(exp.data);
                    end
                end
            end
            if (spi_cs_i && !cs_prev) begin
                if (!last_sent) flag_problem("spi chip select rose inside a frame");
                if (spi_bits != 0) flag_problem("spi chip select rose in the middle of a byte");
            end
        end
        sclk_prev = spi_clk_i;
        cs_prev   = spi_cs_i;
    end

    always @(posedge clk_i) begin
        if (arst_n_i && evt_stb_i) begin
            if (evt_src_i == SRC_UART) begin
                if (uart_ev_q.size() == 0) flag_problem("uart event without a finished frame");
                else mismatch_if(uart_ev_q.pop_front(), "evt_data_o uart");
            end else begin
                if (spi_ev_q.size() == 0) flag_problem("spi event without a finished byte");
                else mismatch_if(spi_ev_q.pop_front(), "evt_data_o spi");
            end
            if (have_src && evt_src_i != last_src && !burst_i) switches++;
            have_src = 1'b1;
            last_src = evt_src_i;
        end
    end

    task automatic mismatch_if(input logic [7:0] exp, input string name);
        if (exp != evt_data_i) mismatch(name, exp, evt_data_i);
    endtask

    task automatic check_end();
        if (spi_q.size() != 0) flag_problem("spi bytes were never sent");
        if (uart_ev_q.size() != 0) flag_problem("uart frames have no event");
        if (spi_ev_q.size() != 0) flag_problem("spi bytes have no event");
        if (switches == 0) flag_problem("events of the two sources never interleaved");
        if (ovf_count == 0) flag_problem("overflow never pulsed in the burst");
        if (first_hits != FIFO_DEPTH) flag_problem("early burst bytes went missing");
    endtask

endmodule

//--- ctrl_pkg.sv
package ctrl_pkg;

    // host write port, one address per command queue
    localparam int ADDR_W = 4;

    localparam logic [ADDR_W-1:0] ADDR_UART     = 4'h0;  // byte for the uart transmitter
    localparam logic [ADDR_W-1:0] ADDR_SPI      = 4'h1;  // spi byte, chip select held after it
    localparam logic [ADDR_W-1:0] ADDR_SPI_LAST = 4'h2;  // spi byte that closes the frame

    // one entry of the spi command FIFO
    typedef struct packed {
        logic       last;  // release chip select once this byte is shifted
        logic [7:0] data;
    } spi_cmd_t;

    // tag carried with every completion event
    typedef enum logic {
        SRC_UART = 1'b0,
        SRC_SPI  = 1'b1
    } ctrl_src_e;

endpackage

//--- ctrl_top.sv
module ctrl_top import ctrl_pkg::*; #(
    parameter int FIFO_DEPTH   = 16,
    parameter int CLKS_PER_BIT = 868,
    parameter int SPI_CLK_DIV  = 4
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              wr_stb_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [7:0]        wr_data_i,
    input  logic              spi_miso_i,
    output logic              uart_tx_o,
    output logic              spi_clk_o,
    output logic              spi_mosi_o,
    output logic              spi_cs_o,
    output logic              evt_stb_o,
    output ctrl_src_e         evt_src_o,
    output logic [7:0]        evt_data_o,
    output logic              overflow_o
);

    logic       uart_push;
    logic       uart_pop;
    logic       uart_empty;
    logic       uart_full;
    logic [7:0] uart_head;
    logic       uart_done;
    logic [7:0] uart_sent;

    logic       spi_push;
    logic       spi_pop;
    logic       spi_empty;
    logic       spi_full;
    spi_cmd_t   spi_wr_cmd;
    spi_cmd_t   spi_head;
    logic       spi_done;
    logic [7:0] spi_rx;

    // address decode, unknown addresses fall through untouched
    assign uart_push       = wr_stb_i && (wr_addr_i == ADDR_UART);
    assign spi_push        = wr_stb_i && (wr_addr_i == ADDR_SPI || wr_addr_i == ADDR_SPI_LAST);
    assign spi_wr_cmd.data = wr_data_i;
    assign spi_wr_cmd.last = (wr_addr_i == ADDR_SPI_LAST);

    // a pop in the same cycle frees the slot, so only a full FIFO without one drops the write
    assign overflow_o = (uart_push && uart_full && !uart_pop) ||
                        (spi_push && spi_full && !spi_pop);

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .T(logic [7:0])) uart_fifo_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .push_i     (uart_push),
        .push_data_i(wr_data_i),
        .pop_i      (uart_pop),
        .head_o     (uart_head),
        .empty_o    (uart_empty),
        .full_o     (uart_full)
    );

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .T(spi_cmd_t)) spi_fifo_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .push_i     (spi_push),
        .push_data_i(spi_wr_cmd),
        .pop_i      (spi_pop),
        .head_o     (spi_head),
        .empty_o    (spi_empty),
        .full_o     (spi_full)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fifo_empty_i(uart_empty),
        .fifo_head_i (uart_head),
        .pop_o       (uart_pop),
        .tx_o        (uart_tx_o),
        .done_o      (uart_done),
        .sent_o      (uart_sent)
    );

    spi_master #(.SPI_CLK_DIV(SPI_CLK_DIV)) spi_master_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fifo_empty_i(spi_empty),
        .fifo_head_i (spi_head),
        .miso_i      (spi_miso_i),
        .pop_o       (spi_pop),
        .sclk_o      (spi_clk_o),
        .mosi_o      (spi_mosi_o),
        .cs_o        (spi_cs_o),
        .done_o      (spi_done),
        .rx_o        (spi_rx)
    );

    event_merge event_merge_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .uart_done_i(uart_done),
        .uart_byte_i(uart_sent),
        .spi_done_i (spi_done),
        .spi_byte_i (spi_rx),
        .evt_stb_o  (evt_stb_o),
        .evt_src_o  (evt_src_o),
        .evt_data_o (evt_data_o)
    );

endmodule

//--- event_merge.sv
module event_merge import ctrl_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       uart_done_i,
    input  logic [7:0] uart_byte_i,
    input  logic       spi_done_i,
    input  logic [7:0] spi_byte_i,
    output logic       evt_stb_o,
    output ctrl_src_e  evt_src_o,
    output logic [7:0] evt_data_o
);

    // spi waits here one cycle when both engines finish together
    logic       pend_vld;
    logic [7:0] pend_data;

    always_ff @(posedge clk_i) begin
        if (uart_done_i) begin
            evt_data_o <= uart_byte_i;
        end else if (pend_vld) begin
            evt_data_o <= pend_data;
        end else if (spi_done_i) begin
            evt_data_o <= spi_byte_i;
        end
        if (uart_done_i && spi_done_i) pend_data <= spi_byte_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            evt_stb_o <= 1'b0;
            evt_src_o <= SRC_UART;
            pend_vld  <= 1'b0;
        end else begin
            evt_stb_o <= uart_done_i | spi_done_i | pend_vld;
            if (uart_done_i) begin
                evt_src_o <= SRC_UART;  // uart wins a collision
                if (spi_done_i) pend_vld <= 1'b1;
            end else if (pend_vld) begin
                evt_src_o <= SRC_SPI;
                pend_vld  <= 1'b0;
            end else if (spi_done_i) begin
                evt_src_o <= SRC_SPI;
            end
        end
    end

endmodule

//--- sim.f
ctrl_pkg.sv
cmd_fifo.sv
uart_tx.sv
spi_master.sv
event_merge.sv
ctrl_top.sv
ctrl_assertions.sv
ctrl_checker.sv
tb_ctrl_top.sv

//--- spi_master.sv
module spi_master import ctrl_pkg::*; #(
    parameter int SPI_CLK_DIV = 4
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       fifo_empty_i,
    input  spi_cmd_t   fifo_head_i,
    input  logic       miso_i,
    output logic       pop_o,
    output logic       sclk_o,
    output logic       mosi_o,
    output logic       cs_o,
    output logic       done_o,
    output logic [7:0] rx_o
);

    localparam int DIV_W = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,     // chip select high
        ST_XFER,     // shifting one byte
        ST_HOLD,     // frame open, waiting for the next byte
        ST_RELEASE   // half period before chip select rises
    } state_t;

    state_t           state;
    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       edge_cnt;
    logic             div_end;
    logic             sclk_q;
    logic             cs_q;
    logic             last_q;
    logic             done_q;
    logic [7:0]       tx_sh;
    logic [7:0]       rx_sh;

    assign div_end = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));
    assign pop_o   = (state == ST_IDLE || state == ST_HOLD) && !fifo_empty_i;

    assign sclk_o = sclk_q;
    assign cs_o   = cs_q;
    assign mosi_o = tx_sh[7];  // msb first, valid a half period before each rising edge
    assign done_o = done_q;
    assign rx_o   = rx_sh;

    // miso is sampled on the rising edge of sclk
    always_ff @(posedge clk_i) begin
        if (state == ST_XFER && div_end && !sclk_q) rx_sh <= {rx_sh[6:0], miso_i};
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= ST_IDLE;
            div_cnt  <= '0;
            edge_cnt <= '0;
            sclk_q   <= 1'b0;
            cs_q     <= 1'b1;
            last_q   <= 1'b0;
            done_q   <= 1'b0;
            tx_sh    <= '0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE, ST_HOLD: begin
                    if (pop_o) begin
                        state   <= ST_XFER;
                        cs_q    <= 1'b0;
                        div_cnt <= '0;
                        tx_sh   <= fifo_head_i.data;
                        last_q  <= fifo_head_i.last;
                    end
                end
                ST_XFER: begin
                    div_cnt <= div_end ? '0 : div_cnt + 1'b1;
                    if (div_end) begin
                        sclk_q <= ~sclk_q;
                        if (sclk_q) begin  // falling edge, move to the next bit
                            tx_sh    <= tx_sh << 1;
                            edge_cnt <= edge_cnt + 1'b1;
                            if (edge_cnt == 3'd7) begin
                                done_q <= 1'b1;
                                state  <= last_q ? ST_RELEASE : ST_HOLD;
                            end
                        end
                    end
                end
                ST_RELEASE: begin
                    div_cnt <= div_end ? '0 : div_cnt + 1'b1;
                    if (div_end) begin
                        cs_q  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- tb_ctrl_top.sv
module tb_ctrl_top;
    import ctrl_pkg::*;

    localparam int FIFO_DEPTH   = 4;
    localparam int CLKS_PER_BIT = 8;
    localparam int SPI_CLK_DIV  = 2;
    localparam int N_ITEMS      = 60;
    localparam int BURST_LEN    = 12;
    localparam int WAIT_LIMIT   = 20000;

    logic              clk;
    logic              arst_n;
    logic              wr_stb;
    logic [ADDR_W-1:0] wr_addr;
    logic [7:0]        wr_data;
    logic              spi_miso = 1'b0;
    logic              uart_tx;
    logic              spi_clk;
    logic              spi_mosi;
    logic              spi_cs;
    logic              evt_stb;
    ctrl_src_e         evt_src;
    logic [7:0]        evt_data;
    logic              overflow;
    logic              burst;

    int uart_wr;
    int spi_wr;
    int uart_ev = 0;
    int spi_ev = 0;
    int tb_errors;

    ctrl_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .SPI_CLK_DIV (SPI_CLK_DIV)
    ) ctrl_top_inst (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .wr_stb_i  (wr_stb),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .spi_miso_i(spi_miso),
        .uart_tx_o (uart_tx),
        .spi_clk_o (spi_clk),
        .spi_mosi_o(spi_mosi),
        .spi_cs_o  (spi_cs),
        .evt_stb_o (evt_stb),
        .evt_src_o (evt_src),
        .evt_data_o(evt_data),
        .overflow_o(overflow)
    );

    ctrl_checker #(.FIFO_DEPTH(FIFO_DEPTH), .CLKS_PER_BIT(CLKS_PER_BIT)) checker_inst (
        .clk_i(clk), .arst_n_i(arst_n), .burst_i(burst),
        .wr_stb_i(wr_stb), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .uart_tx_i(uart_tx), .spi_clk_i(spi_clk), .spi_mosi_i(spi_mosi), .spi_cs_i(spi_cs),
        .evt_stb_i(evt_stb), .evt_src_i(evt_src), .evt_data_i(evt_data), .overflow_i(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) spi_miso <= spi_mosi;  // slave echoes mosi one clock late

    always @(posedge clk) begin
        if (evt_stb && evt_src == SRC_UART) uart_ev <= uart_ev + 1;
        if (evt_stb && evt_src == SRC_SPI) spi_ev <= spi_ev + 1;
    end

    task automatic expect_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Fail %s expected %h got %h", name, exp, got);
            tb_errors++;
        end
    endtask

    // single write strobe, called on a falling edge and returns on the next one
    task automatic write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
        wr_stb  = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_stb = 1'b0;
    endtask

    // holds back until the engine has room for one more item
    task automatic wait_room(input bit to_spi);
        int cycles;
        cycles = 0;
        while ((to_spi ? spi_wr - spi_ev : uart_wr - uart_ev) >= FIFO_DEPTH) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout while waiting for room in the %s queue",
                         to_spi ? "spi" : "uart");
                tb_errors++;
                break;
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        int sel;
        int cycles;
        int idle;
        void'($urandom(32'hd09c0a83));
        arst_n = 1'b0;
        wr_stb = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        burst = 1'b0;
        uart_wr = 0;
        spi_wr = 0;
        tb_errors = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        expect_bit("uart_tx_o", 1'b1, uart_tx);
        expect_bit("spi_cs_o", 1'b1, spi_cs);
        expect_bit("spi_clk_o", 1'b0, spi_clk);
        expect_bit("spi_mosi_o", 1'b0, spi_mosi);
        expect_bit("evt_stb_o", 1'b0, evt_stb);
        expect_bit("overflow_o", 1'b0, overflow);

        for (int i = 0; i < N_ITEMS; i++) begin
            sel = $urandom_range(0, 7);
            if (sel < 4) begin
                wait_room(1'b0);
                write(ADDR_UART, 8'($urandom));
                uart_wr++;
            end else if (sel < 7) begin
                wait_room(1'b1);
                write((sel == 6) ? ADDR_SPI_LAST : ADDR_SPI, 8'($urandom));
                spi_wr++;
            end else begin
                write(ADDR_W'($urandom_range(3, 15)), 8'($urandom));  // nobody listens here
            end
            repeat ($urandom_range(0, 3)) @(negedge clk);
        end
        wait_room(1'b1);
        write(ADDR_SPI_LAST, 8'($urandom));  // close any open frame
        spi_wr++;

        cycles = 0;
        while (uart_ev != uart_wr || spi_ev != spi_wr) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout while draining the paced traffic");
                tb_errors++;
                break;
            end
            @(negedge clk);
            cycles++;
        end
        repeat (2 * SPI_CLK_DIV + 2) @(negedge clk);

        burst = 1'b1;
        for (int i = 0; i < BURST_LEN; i++) write(ADDR_UART, 8'(8'h40 + i));

        // the burst is over once the line has been quiet for more than a frame
        cycles = 0;
        idle = 0;
        while (idle < 12 * CLKS_PER_BIT) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout while draining the burst");
                tb_errors++;
                break;
            end
            @(negedge clk);
            idle = (evt_stb || !uart_tx) ? 0 : idle + 1;
            cycles++;
        end

        checker_inst.check_end();
        $display("errors: checker %0d, testbench %0d", checker_inst.errors, tb_errors);
        if (checker_inst.errors == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       fifo_empty_i,
    input  logic [7:0] fifo_head_i,
    output logic       pop_o,
    output logic       tx_o,
    output logic       done_o,
    output logic [7:0] sent_o
);

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t            state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift;
    logic              bit_end;

    assign bit_end = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
    assign pop_o   = (state == ST_IDLE) && !fifo_empty_i;
    assign done_o  = (state == ST_STOP) && bit_end;  // last cycle of the stop bit

    always_comb begin
        case (state)
            ST_START: tx_o = 1'b0;
            ST_DATA:  tx_o = shift[0];  // lsb first
            default:  tx_o = 1'b1;      // idle and stop bit are both mark
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            shift  <= fifo_head_i;
            sent_o <= fifo_head_i;
        end else if (state == ST_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= ST_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (state != ST_IDLE) baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                ST_IDLE:  if (pop_o) state <= ST_START;
                ST_START: if (bit_end) state <= ST_DATA;
                ST_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;  // wraps back to zero after eight bits
                        if (bit_cnt == 3'd7) state <= ST_STOP;
                    end
                end
                ST_STOP:  if (bit_end) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

endmodule
